// ==== twiddle_rom.mem ====
// cos(2*pi*i/256) in Q2.14, one 16-bit hex word per entry, i = 0 to 64
4000
3FFB
3FEC
3FD4
3FB1
3F85
3F4F
3F0F
3EC5
3E72
3E15
3DAF
3D3F
3CC5
3C42
3BB6
3B21
3A82
39DB
392B
3871
37B0
36E5
3612
3537
3453
3368
3274
3179
3076
2F6C
2E5A
2D41
2C21
2AFB
29CE
289A
2760
2620
24DA
238E
223D
20E7
1F8C
1E2B
1CC6
1B5D
19EF
187E
1709
1590
1413
1294
1112
0F8D
0E06
0C7C
0AF1
0964
07D6
0646
04B5
0324
0192
0000

// ==== verilog.f ====
fft_pkg.sv
bfly_addsub.sv
twiddle_gen.sv
cmplx_mult.sv
fft_bfly.sv
tb_clkgen.sv
fft_bfly_chk.sv
fft_bfly_tb.sv

// ==== fft_bfly_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// model rebuilds the cosine table with $cos and applies the quadrant fold
// every output must appear exactly three cycles after its input
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fft_bfly_tb import fft_pkg::*; ();

    localparam int LATENCY = 3;
    localparam int TIMEOUT = 50;

    typedef struct packed {
        int x_re;
        int x_im;
        int y_re;
        int y_im;
        int cycle;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       in_valid;
    cplx_t      a;
    cplx_t      b;
    angle_t     k;
    logic       out_valid;
    cplx_wide_t x;
    cplx_y_t    y;

    int      seed = 97;
    int      cycle_cnt = 0;
    int      in_cnt = 0;
    int      out_cnt = 0;
    int      value_errs = 0;
    int      other_errs = 0;
    int      assert_errs = 0;
    int      cos_tab [0:QUARTER];
    angle_t  bound_k [10] = '{8'd0, 8'd1, 8'd63, 8'd64, 8'd65,
                              8'd127, 8'd128, 8'd191, 8'd192, 8'd255};
    expect_t exp_q [$];

    tb_clkgen tb_clkgen_i (.clk(clk), .reset(reset));

    fft_bfly fft_bfly_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .k         (k),
        .out_valid (out_valid),
        .x         (x),
        .y         (y)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // 16384 is +1.0 in Q2.14
    function automatic int cos_entry(int i);
        return $rtoi(16384.0 * $cos(2.0 * 3.14159265358979 * i / 256.0) + 0.5);
    endfunction

    function automatic expect_t ref_butterfly(cplx_t av, cplx_t bv, angle_t kv);
        expect_t e;
        int      q;
        int      o;
        int      c;
        int      s;
        longint  d_re;
        longint  d_im;
        q = kv / 64;
        o = kv % 64;
        c = q[0] ? cos_tab[64-o] : cos_tab[o];
        s = q[0] ? cos_tab[o] : cos_tab[64-o];
        if (q == 1 || q == 2) c = -c;
        if (q >= 2) s = -s;
        e.x_re = int'(av.re) + int'(bv.re);
        e.x_im = int'(av.im) + int'(bv.im);
        d_re = longint'(av.re) - longint'(bv.re);
        d_im = longint'(av.im) - longint'(bv.im);
        // (d_re + j*d_im) * (c - j*s), floored
        e.y_re = int'((d_re * c + d_im * s) >>> TW_FRAC);
        e.y_im = int'((d_im * c - d_re * s) >>> TW_FRAC);
        e.cycle = 0;
        return e;
    endfunction

    function automatic cplx_t rand_cplx();
        cplx_t r;
        r.re = sample_t'($random(seed));
        r.im = sample_t'($random(seed));
        return r;
    endfunction

    function automatic sample_t extreme(logic hi);
        return hi ? 16'sh7FFF : 16'sh8000;
    endfunction

    task automatic drive(input logic v, input cplx_t av, input cplx_t bv, input angle_t kv);
        @(posedge clk);
        #1;
        in_valid = v;
        a = av;
        b = bv;
        k = kv;
    endtask

    task automatic drain();
        int n;
        n = 0;
        drive(1'b0, '0, '0, '0);
        while (exp_q.size() > 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout, %0d outputs still missing after %0d cycles", exp_q.size(), n);
            other_errs++;
        end
    endtask

    task automatic check_value(input string name, input int expv, input int actv);
        assert (actv == expv) else begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expv, actv);
            value_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // capture on the input edge, compare on the falling edge

    always @(posedge clk) begin
        expect_t e;
        cycle_cnt++;
        if (!reset && in_valid) begin
            e = ref_butterfly(a, b, k);
            e.cycle = cycle_cnt;
            exp_q.push_back(e);
            in_cnt++;
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (!reset && out_valid) begin
            out_cnt++;
            assert (exp_q.size() > 0) else begin
                $display("out_valid high at %0t with no item outstanding", $time);
                other_errs++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_value("x.re", e.x_re, int'(x.re));
                check_value("x.im", e.x_im, int'(x.im));
                check_value("y.re", e.y_re, int'(y.re));
                check_value("y.im", e.y_im, int'(y.im));
                // the sink takes this output on the coming edge
                assert (cycle_cnt + 1 - e.cycle == LATENCY) else begin
                    $display("item from cycle %0d came out in cycle %0d",
                             e.cycle, cycle_cnt + 1);
                    other_errs++;
                end
            end
        end
    end

    initial begin
        int n;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        k = '0;
        for (int i = 0; i <= QUARTER; i++) begin
            cos_tab[i] = cos_entry(i);
        end
        // first edge falls inside reset
        @(posedge clk);
        n = 0;
        while ((reset !== 1'b0) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (reset === 1'b0) else begin
            $display("timeout, reset never released");
            other_errs++;
        end

        // idle after reset, then a single item
        repeat (4) drive(1'b0, '0, '0, '0);
        drive(1'b1, rand_cplx(), rand_cplx(), 8'd37);
        drain();

        repeat (200) drive(1'b1, rand_cplx(), rand_cplx(), angle_t'($random(seed)));
        drain();

        // diff of 1.0 and j*1.0 makes y show the twiddle itself
        foreach (bound_k[i]) begin
            drive(1'b1, cplx_t'{16'sd16384, 16'sd0}, '0, bound_k[i]);
            drive(1'b1, cplx_t'{16'sd0, 16'sd16384}, '0, bound_k[i]);
        end
        drain();

        for (int m = 0; m < 16; m++) begin
            for (int j = 0; j < 4; j++) begin
                drive(1'b1, cplx_t'{extreme(m[0]), extreme(m[1])},
                      cplx_t'{extreme(m[2]), extreme(m[3])}, angle_t'(32 + 64 * j));
            end
        end
        drain();

        repeat (300) begin
            drive(($random(seed) & 1) == 1, rand_cplx(), rand_cplx(), angle_t'($random(seed)));
        end
        drain();

        assert (in_cnt == out_cnt) else begin
            $display("%0d items accepted but %0d outputs seen", in_cnt, out_cnt);
            other_errs++;
        end
        assert_errs = fft_bfly_i.fft_bfly_chk_i.fail_count;
        $display("items %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 in_cnt, value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== fft_bfly_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// bound into fft_bfly, covers the valid pipeline only, not the data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fft_bfly_chk (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic out_valid
);

    int fail_count = 0;

    // out_valid repeats in_valid three edges later
    latency_a: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(in_valid, 3))
    else begin
        $error("out_valid does not follow in_valid by three cycles");
        fail_count++;
    end

    reset_a: assert property (@(posedge clk) reset |-> !out_valid)
    else begin
        $error("out_valid high while reset is active");
        fail_count++;
    end

    known_a: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
    else begin
        $error("out_valid is unknown after reset");
        fail_count++;
    end

endmodule

bind fft_bfly fft_bfly_chk fft_bfly_chk_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

// ==== tb_clkgen.sv ====
////////////////////////////////////////////////////////////////////////////
// 10 ns clock, reset high across the first 5 rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b0;
        // rise after time zero so the flops see an edge
        #1 reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== fft_bfly.sv ====
////////////////////////////////////////////////////////////////////////////
// fixed latency of PIPE_LAT cycles, one item per clock, no back-pressure
// sink must take x and y on every cycle out_valid is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fft_bfly import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  cplx_t      a,
    input  cplx_t      b,
    input  angle_t     k,
    output logic       out_valid,
    output cplx_wide_t x,
    output cplx_y_t    y
);

    cplx_wide_t sum;
    cplx_wide_t diff;
    logic       sum_valid;
    cplx_tw_t   w;

    // sum waits for the two multiplier stages
    cplx_wide_t sum_dly [PIPE_LAT-1];

    bfly_addsub bfly_addsub_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sum       (sum),
        .diff      (diff),
        .sum_valid (sum_valid)
    );

    twiddle_gen twiddle_gen_i (
        .clk   (clk),
        .reset (reset),
        .k     (k),
        .w     (w)
    );

    cmplx_mult cmplx_mult_i (
        .clk        (clk),
        .reset      (reset),
        .diff       (diff),
        .w          (w),
        .diff_valid (sum_valid),
        .y          (y),
        .y_valid    (out_valid)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PIPE_LAT - 1; i++) begin
                sum_dly[i] <= '0;
            end
        end else begin
            sum_dly[0] <= sum;
            for (int i = 1; i < PIPE_LAT - 1; i++) begin
                sum_dly[i] <= sum_dly[i-1];
            end
        end
    end

    assign x = sum_dly[PIPE_LAT-2];

endmodule

// ==== cmplx_mult.sv ====
////////////////////////////////////////////////////////////////////////////
// two register stages; y is floored by the arithmetic shift, not rounded
// output fits 18 bits for any 17-bit diff and unit-magnitude twiddle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cmplx_mult import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  cplx_wide_t diff,
    input  cplx_tw_t   w,
    input  logic       diff_valid,
    output cplx_y_t    y,
    output logic       y_valid
);

    prod_t   p_rr;
    prod_t   p_ii;
    prod_t   p_ri;
    prod_t   p_ir;
    logic    prod_valid;
    prod_t   acc_re;
    prod_t   acc_im;
    cplx_y_t y_next;

    //////////////////////////////////////////////////////////////////////////
    // stage one, partial products

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p_rr       <= '0;
            p_ii       <= '0;
            p_ri       <= '0;
            p_ir       <= '0;
            prod_valid <= 1'b0;
        end else begin
            p_rr       <= diff.re * w.re;
            p_ii       <= diff.im * w.im;
            p_ri       <= diff.re * w.im;
            p_ir       <= diff.im * w.re;
            prod_valid <= diff_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // stage two, combine and scale

    // sums stay below 2^31, no growth needed
    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;

    always_comb begin
        y_next.re = yout_t'(acc_re >>> TW_FRAC);
        y_next.im = yout_t'(acc_im >>> TW_FRAC);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y       <= '0;
            y_valid <= 1'b0;
        end else begin
            y       <= y_next;
            y_valid <= prod_valid;
        end
    end

endmodule

// ==== twiddle_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// twiddle_rom.mem must hold 65 hex words of cos(2*pi*i/256) in Q2.14
// w is valid one cycle after k is presented
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module twiddle_gen import fft_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  angle_t   k,
    output cplx_tw_t w
);

    // quarter-wave cosine, entries 0..64
    twiddle_t tw_rom [0:QUARTER];

    initial begin
        $readmemh("twiddle_rom.mem", tw_rom);
    end

    logic [1:0] quad;
    logic [5:0] offs;
    rom_addr_t  addr_lo;
    rom_addr_t  addr_hi;
    twiddle_t   val_lo;
    twiddle_t   val_hi;
    cplx_tw_t   w_next;

    assign quad    = k[7:6];
    assign offs    = k[5:0];
    assign addr_lo = rom_addr_t'(offs);
    assign addr_hi = rom_addr_t'(QUARTER - offs);

    // two read ports, same table
    assign val_lo = tw_rom[addr_lo];
    assign val_hi = tw_rom[addr_hi];

    // fold by quadrant; im is -sin
    always_comb begin
        case (quad)
            2'd0: begin
                w_next.re = val_lo;
                w_next.im = -val_hi;
            end
            2'd1: begin
                w_next.re = -val_hi;
                w_next.im = -val_lo;
            end
            2'd2: begin
                w_next.re = -val_lo;
                w_next.im = val_hi;
            end
            default: begin
                w_next.re = val_hi;
                w_next.im = val_lo;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w <= '0;
        end else begin
            w <= w_next;
        end
    end

endmodule

// ==== bfly_addsub.sv ====
////////////////////////////////////////////////////////////////////////////
// first pipeline stage, one extra bit keeps A+B and A-B exact
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module bfly_addsub import fft_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  cplx_t      a,
    input  cplx_t      b,
    output cplx_wide_t sum,
    output cplx_wide_t diff,
    output logic       sum_valid
);

    cplx_wide_t sum_next;
    cplx_wide_t diff_next;

    // sign-extend before the add so nothing wraps
    always_comb begin
        sum_next.re  = wide_t'(a.re) + wide_t'(b.re);
        sum_next.im  = wide_t'(a.im) + wide_t'(b.im);
        diff_next.re = wide_t'(a.re) - wide_t'(b.re);
        diff_next.im = wide_t'(a.im) - wide_t'(b.im);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum       <= '0;
            diff      <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum       <= sum_next;
            diff      <= diff_next;
            sum_valid <= in_valid;
        end
    end

endmodule

// ==== fft_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// twiddles are Q2.14, so +1.0 is exactly 16384 and fits the 16-bit type
// angle index k covers a full turn in 256 steps
////////////////////////////////////////////////////////////////////////////

package fft_pkg;

    // component widths
    localparam int SAMPLE_W = 16;
    localparam int WIDE_W   = SAMPLE_W + 1;
    localparam int TW_W     = 16;
    localparam int PROD_W   = WIDE_W + TW_W;
    localparam int YOUT_W   = 18;
    localparam int ANGLE_W  = 8;
    localparam int ADDR_W   = 7;

    localparam int TW_FRAC  = 14;
    localparam int QUARTER  = 64;
    localparam int PIPE_LAT = 3;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [WIDE_W-1:0]   wide_t;
    typedef logic signed [TW_W-1:0]     twiddle_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [YOUT_W-1:0]   yout_t;
    typedef logic [ANGLE_W-1:0]         angle_t;
    typedef logic [ADDR_W-1:0]          rom_addr_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        wide_t re;
        wide_t im;
    } cplx_wide_t;

    // im carries -sin, so W = re + j*im directly
    typedef struct packed {
        twiddle_t re;
        twiddle_t im;
    } cplx_tw_t;

    typedef struct packed {
        yout_t re;
        yout_t im;
    } cplx_y_t;

endpackage
